/* common/decode_pkg.sv */
// decode package: widths, opcode classes, bubble code and instruction field positions
package decode_pkg;

    // datapath and instruction widths
    localparam int xlen           = 64;
    localparam int instr_width    = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;

    // immediate widths
    // i, s and sb formats share the 12-bit field
    localparam int imm12_width    = 12;
    // u and uj formats
    localparam int uimm_width     = 20;

    // funct3 on top of the 7-bit major opcode
    localparam int op_code_width  = 10;

    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [xlen-1:0]           xlen_t;
    typedef logic [instr_width-1:0]    instr_t;
    typedef logic [imm12_width-1:0]    imm12_t;
    typedef logic [uimm_width-1:0]     uimm_t;
    typedef logic [op_code_width-1:0]  op_code_t;

    // major opcode classes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        // register-register, 64 and 32 bit
        op_r64    = 7'b0110011,
        op_r32    = 7'b0111011,
        // i-format group
        op_jalr   = 7'b1100111,
        op_load   = 7'b0000011,
        op_imm64  = 7'b0010011,
        op_imm32  = 7'b0011011,
        // no destination register
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        // upper immediate and jump
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_fence  = 7'b0001111,
        // ecall, ebreak, csr access
        op_system = 7'b1110011
    } op_class_e;

    // fence with funct3 zero, harmless in execute
    localparam op_code_t bubble_op_code = 10'h00f;

    // field positions, low and high bit
    localparam int opcode_lo = 0;
    localparam int opcode_hi = 6;

    localparam int rd_lo     = 7;
    localparam int rd_hi     = 11;

    localparam int funct3_lo = 12;
    localparam int funct3_hi = 14;

    localparam int rs1_lo    = 15;
    localparam int rs1_hi    = 19;

    localparam int rs2_lo    = 20;
    localparam int rs2_hi    = 24;

    // upper bits of the split store immediate
    localparam int funct7_lo = 25;
    localparam int funct7_hi = 31;

    // i-format immediate
    localparam int imm_i_lo  = 20;
    localparam int imm_i_hi  = 31;

    // u-format immediate
    localparam int imm_u_lo  = 12;
    localparam int imm_u_hi  = 31;

endpackage

/* decode/instr_field_decoder.sv */
// instruction field decoder: splits an instruction into class, register numbers and immediates
`timescale 1ns/1ps

module instr_field_decoder (
    input  decode_pkg::instr_t    instr,
    input  logic                  is_flush,
    output decode_pkg::reg_addr_t rs1,
    output decode_pkg::reg_addr_t rs2,
    output decode_pkg::reg_addr_t rd,
    output decode_pkg::op_code_t  op_code,
    output decode_pkg::imm12_t    imm12,
    output decode_pkg::uimm_t     uimm
);
    import decode_pkg::*;

    op_class_e op_class;
    // which register fields the format really carries
    logic      has_rs1;
    logic      has_rs2;
    logic      has_rd;

    always_comb begin
        op_class = op_class_e'(instr[opcode_hi:opcode_lo]);
        // funct3 and opcode, formed for every class
        op_code  = {instr[funct3_hi:funct3_lo], instr[opcode_hi:opcode_lo]};

        // defaults cover unknown classes
        has_rs1  = 1'b0;
        has_rs2  = 1'b0;
        has_rd   = 1'b0;
        imm12    = '0;
        uimm     = '0;

        case (op_class)
            op_r64, op_r32: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                has_rd  = 1'b1;
            end

            op_jalr, op_load, op_imm64, op_imm32: begin
                has_rs1 = 1'b1;
                has_rd  = 1'b1;
                imm12   = instr[imm_i_hi:imm_i_lo];
            end

            op_system: begin
                // csr number or ecall/ebreak selector
                has_rs1 = 1'b1;
                has_rd  = 1'b1;
                imm12   = instr[imm_i_hi:imm_i_lo];
            end

            op_store: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                // offset split around rd position
                imm12   = {instr[funct7_hi:funct7_lo], instr[rd_hi:rd_lo]};
            end

            op_branch: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                // offset bits 12:1, bit 0 always zero
                imm12   = {instr[31], instr[7], instr[30:25], instr[11:8]};
            end

            op_lui, op_auipc: begin
                has_rd = 1'b1;
                uimm   = instr[imm_u_hi:imm_u_lo];
            end

            op_jal: begin
                has_rd = 1'b1;
                // jump offset bits 20:1
                uimm   = {instr[31], instr[19:12], instr[20], instr[30:21]};
            end

            op_fence: begin
                // ordering only, nothing to read or write
            end

            default: begin
                // unknown class keeps the zero defaults
            end
        endcase

        rs1 = has_rs1 ? instr[rs1_hi:rs1_lo] : '0;
        rs2 = has_rs2 ? instr[rs2_hi:rs2_lo] : '0;
        // flushed instruction must not claim a destination
        rd  = (has_rd && !is_flush) ? instr[rd_hi:rd_lo] : '0;
    end

endmodule

/* decode/hazard_detector.sv */
// hazard detector: read-after-write check of source registers against downstream destinations
`timescale 1ns/1ps

module hazard_detector (
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  decode_pkg::reg_addr_t alu_reg_dest,
    input  decode_pkg::reg_addr_t mem_reg_dest,
    input  decode_pkg::reg_addr_t wb_reg_dest,
    input  logic                  alu_is_store,
    output logic                  hazard
);
    import decode_pkg::*;

    logic alu_match;
    logic mem_match;
    logic wb_match;

    // x0 is never a real dependency
    function automatic logic dest_match(input reg_addr_t dest,
                                        input reg_addr_t src_a,
                                        input reg_addr_t src_b);
        logic hit_a;
        logic hit_b;
        hit_a = (src_a != '0) && (dest == src_a);
        hit_b = (src_b != '0) && (dest == src_b);
        return (dest != '0) && (hit_a || hit_b);
    endfunction

    always_comb begin
        alu_match = dest_match(alu_reg_dest, rs1, rs2);
        mem_match = dest_match(mem_reg_dest, rs1, rs2);
        wb_match  = dest_match(wb_reg_dest, rs1, rs2);

        // a store in alu writes no register
        hazard = (alu_match && !alu_is_store) || mem_match || wb_match;
    end

endmodule

/* decode/register_file.sv */
// integer register file: 32 x 64-bit, one synchronous write port, two registered read ports
`timescale 1ns/1ps

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::reg_addr_t rd_addr_a,
    input  decode_pkg::reg_addr_t rd_addr_b,
    input  logic                  wr_en,
    input  decode_pkg::reg_addr_t wr_addr,
    input  decode_pkg::xlen_t     wr_data,
    output decode_pkg::xlen_t     rd_data_a,
    output decode_pkg::xlen_t     rd_data_b
);
    import decode_pkg::*;

    xlen_t regs [num_regs];

    // write port, x0 stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read ports, one cycle latency
    // same-edge write is not forwarded, old value comes out
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data_a <= '0;
            rd_data_b <= '0;
        end else begin
            rd_data_a <= (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
            rd_data_b <= (rd_addr_b == '0) ? '0 : regs[rd_addr_b];
        end
    end

endmodule

/* decode/decode_stage.sv */
// decode stage top: field decode, hazard check, register read and the decode/execute register
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    // from fetch
    input  decode_pkg::instr_t    instr,
    input  decode_pkg::xlen_t     prog_counter,
    input  logic                  is_flush,
    // writeback port
    input  logic                  wr_en,
    input  decode_pkg::reg_addr_t destn_reg,
    input  decode_pkg::xlen_t     destn_data,
    // destinations in flight
    input  decode_pkg::reg_addr_t alu_reg_dest,
    input  decode_pkg::reg_addr_t mem_reg_dest,
    input  decode_pkg::reg_addr_t wb_reg_dest,
    input  logic                  alu_is_store,
    // to execute
    output decode_pkg::xlen_t     rd_data_a,
    output decode_pkg::xlen_t     rd_data_b,
    output decode_pkg::reg_addr_t reg_dest,
    output decode_pkg::reg_addr_t reg_a,
    output decode_pkg::imm12_t    imm12,
    output decode_pkg::uimm_t     uimm,
    output decode_pkg::op_code_t  op_code,
    output decode_pkg::instr_t    out_instr,
    output decode_pkg::xlen_t     curr_pc,
    output logic                  stall
);
    import decode_pkg::*;

    // decoder outputs
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    op_code_t  dec_op_code;
    imm12_t    dec_imm12;
    uimm_t     dec_uimm;

    logic      hazard;

    // raw register file reads
    xlen_t     rf_data_a;
    xlen_t     rf_data_b;

    instr_field_decoder i_instr_field_decoder (
        .instr    (instr),
        .is_flush (is_flush),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rd       (dec_rd),
        .op_code  (dec_op_code),
        .imm12    (dec_imm12),
        .uimm     (dec_uimm)
    );

    hazard_detector i_hazard_detector (
        .rs1          (dec_rs1),
        .rs2          (dec_rs2),
        .alu_reg_dest (alu_reg_dest),
        .mem_reg_dest (mem_reg_dest),
        .wb_reg_dest  (wb_reg_dest),
        .alu_is_store (alu_is_store),
        .hazard       (hazard)
    );

    // writes go through even while stalled
    register_file i_register_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (dec_rs1),
        .rd_addr_b (dec_rs2),
        .wr_en     (wr_en),
        .wr_addr   (destn_reg),
        .wr_data   (destn_data),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b)
    );

    // decode/execute register
    always_ff @(posedge clk) begin
        if (reset) begin
            op_code   <= '0;
            reg_dest  <= '0;
            reg_a     <= '0;
            imm12     <= '0;
            uimm      <= '0;
            stall     <= 1'b0;
            curr_pc   <= '0;
            out_instr <= '0;
        end else begin
            // pc and raw instruction pass through either way
            curr_pc   <= prog_counter;
            out_instr <= instr;
            stall     <= hazard;
            if (hazard) begin
                // bubble into execute
                op_code  <= bubble_op_code;
                reg_dest <= '0;
                reg_a    <= '0;
                imm12    <= '0;
                uimm     <= '0;
            end else begin
                op_code  <= dec_op_code;
                reg_dest <= dec_rd;
                reg_a    <= dec_rs1;
                imm12    <= dec_imm12;
                uimm     <= dec_uimm;
            end
        end
    end

    // read data lines up with stall, so mask it in the bubble cycle
    assign rd_data_a = stall ? '0 : rf_data_a;
    assign rd_data_b = stall ? '0 : rf_data_b;

endmodule

/* sim/decode_vectors.svh */
// decode test vectors: instruction rows with writeback, stage destinations and expected fields
`ifndef decode_vectors_svh
`define decode_vectors_svh

// row layout, first line of each row is stimulus, second line is expected output
// instr, flush, wr_en, wr_reg, wr_data, alu_dest, mem_dest, wb_dest, alu_store
// op_code, reg_dest, reg_a, second source read, imm12, uimm, stall
typedef struct packed {
    instr_t    instr;
    logic      flush;
    logic      wr_en;
    reg_addr_t wr_reg;
    xlen_t     wr_data;
    reg_addr_t alu_dest;
    reg_addr_t mem_dest;
    reg_addr_t wb_dest;
    logic      alu_store;
    op_code_t  exp_op_code;
    reg_addr_t exp_reg_dest;
    reg_addr_t exp_reg_a;
    // register behind rd_data_b, zero when the format reads none
    reg_addr_t exp_src_b;
    imm12_t    exp_imm12;
    uimm_t     exp_uimm;
    logic      exp_stall;
} vector_t;

localparam int num_vectors = 20;

localparam vector_t vectors [num_vectors] = '{
    // add x1,x2,x3 / sub x4,x2,x3 / addw x6,x2,x3 with writes to x2, x3 and x0
    '{32'h003100b3, 1'b0, 1'b1, 5'd2, 64'h0123_4567_89ab_cdef, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h033, 5'd1, 5'd2, 5'd3, 12'h000, 20'h00000, 1'b0},
    '{32'h40310233, 1'b0, 1'b1, 5'd3, 64'hfedc_ba98_7654_3210, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h033, 5'd4, 5'd2, 5'd3, 12'h000, 20'h00000, 1'b0},
    '{32'h0031033b, 1'b0, 1'b1, 5'd0, 64'hdead_beef_dead_beef, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h03b, 5'd6, 5'd2, 5'd3, 12'h000, 20'h00000, 1'b0},
    // i formats: addi x7,x3,-1 / ld x8,16(x2) with x5 write / addiw x9,x0,0x7ff / jalr x1,8(x5)
    '{32'hfff18393, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h013, 5'd7, 5'd3, 5'd0, 12'hfff, 20'h00000, 1'b0},
    '{32'h01013403, 1'b0, 1'b1, 5'd5, 64'h0000_0000_0000_1234, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h183, 5'd8, 5'd2, 5'd0, 12'h010, 20'h00000, 1'b0},
    '{32'h7ff0049b, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h01b, 5'd9, 5'd0, 5'd0, 12'h7ff, 20'h00000, 1'b0},
    '{32'h008280e7, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h067, 5'd1, 5'd5, 5'd0, 12'h008, 20'h00000, 1'b0},
    // sd x3,40(x2) and a branch, both without destination
    '{32'h02313423, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h1a3, 5'd0, 5'd2, 5'd3, 12'h028, 20'h00000, 1'b0},
    '{32'h82310463, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h063, 5'd0, 5'd2, 5'd3, 12'h814, 20'h00000, 1'b0},
    // lui, auipc, jal
    '{32'habcde537, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h337, 5'd10, 5'd0, 5'd0, 12'h000, 20'habcde, 1'b0},
    '{32'h00012597, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h117, 5'd11, 5'd0, 5'd0, 12'h000, 20'h00012, 1'b0},
    '{32'h2ab5a0ef, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h16f, 5'd1, 5'd0, 5'd0, 12'h000, 20'h2d555, 1'b0},
    // fence, then csrrs x12,0x300,x2
    '{32'h0ff0000f, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h00f, 5'd0, 5'd0, 5'd0, 12'h000, 20'h00000, 1'b0},
    '{32'h30012673, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h173, 5'd12, 5'd2, 5'd0, 12'h300, 20'h00000, 1'b0},
    // flushed add loses only its destination
    '{32'h003100b3, 1'b1, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h033, 5'd0, 5'd2, 5'd3, 12'h000, 20'h00000, 1'b0},
    // mem hazard with a write to x7 in the same cycle
    '{32'h003100b3, 1'b0, 1'b1, 5'd7, 64'h5a5a_a5a5_0f0f_f0f0, 5'd0, 5'd2, 5'd0, 1'b0,
      10'h00f, 5'd0, 5'd0, 5'd0, 12'h000, 20'h00000, 1'b1},
    // wb hazard on rs2, then alu hazard
    '{32'h003100b3, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd3, 1'b0,
      10'h00f, 5'd0, 5'd0, 5'd0, 12'h000, 20'h00000, 1'b1},
    '{32'h003100b3, 1'b0, 1'b0, 5'd0, 64'h0, 5'd2, 5'd0, 5'd0, 1'b0,
      10'h00f, 5'd0, 5'd0, 5'd0, 12'h000, 20'h00000, 1'b1},
    // store in alu stage is no dependency
    '{32'h003100b3, 1'b0, 1'b0, 5'd0, 64'h0, 5'd3, 5'd0, 5'd0, 1'b1,
      10'h033, 5'd1, 5'd2, 5'd3, 12'h000, 20'h00000, 1'b0},
    // add x13,x0,x7 sees the write made during the stall
    '{32'h007006b3, 1'b0, 1'b0, 5'd0, 64'h0, 5'd0, 5'd0, 5'd0, 1'b0,
      10'h033, 5'd13, 5'd0, 5'd7, 12'h000, 20'h00000, 1'b0}
};

`endif

/* sim/decode_stage_tb.sv */
// decode stage testbench: reset, register sweep, table and random rows against a register model
`timescale 1ns/1ps

module decode_stage_tb;
    import decode_pkg::*;

    `include "decode_vectors.svh"

    localparam int num_random_rows = 16;
    localparam int reset_timeout   = 20;

    logic      clk;
    logic      reset;
    instr_t    instr;
    xlen_t     prog_counter;
    logic      is_flush;
    logic      wr_en;
    reg_addr_t destn_reg;
    xlen_t     destn_data;
    reg_addr_t alu_reg_dest;
    reg_addr_t mem_reg_dest;
    reg_addr_t wb_reg_dest;
    logic      alu_is_store;

    xlen_t     rd_data_a;
    xlen_t     rd_data_b;
    reg_addr_t reg_dest;
    reg_addr_t reg_a;
    imm12_t    imm12;
    uimm_t     uimm;
    op_code_t  op_code;
    instr_t    out_instr;
    xlen_t     curr_pc;
    logic      stall;

    // expected register contents
    xlen_t     reg_model [num_regs];
    // rows applied so far, also sets the pc
    int        row_count;

    decode_stage i_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .prog_counter (prog_counter),
        .is_flush     (is_flush),
        .wr_en        (wr_en),
        .destn_reg    (destn_reg),
        .destn_data   (destn_data),
        .alu_reg_dest (alu_reg_dest),
        .mem_reg_dest (mem_reg_dest),
        .wb_reg_dest  (wb_reg_dest),
        .alu_is_store (alu_is_store),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .reg_dest     (reg_dest),
        .reg_a        (reg_a),
        .imm12        (imm12),
        .uimm         (uimm),
        .op_code      (op_code),
        .out_instr    (out_instr),
        .curr_pc      (curr_pc),
        .stall        (stall)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // add x0 reading register r and its mirror
    function automatic vector_t sweep_row(input int r);
        vector_t row;
        row             = '0;
        row.instr       = {7'b0000000, 5'(31 - r), 5'(r), 3'b000, 5'd0, 7'b0110011};
        row.exp_op_code = 10'h033;
        row.exp_reg_a   = 5'(r);
        row.exp_src_b   = 5'(31 - r);
        return row;
    endfunction

    // r-type with random registers and funct3, no stage destinations
    function automatic vector_t random_r_row();
        vector_t    row;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic [2:0] funct3;
        rs1              = 5'($urandom_range(31, 0));
        rs2              = 5'($urandom_range(31, 0));
        rd               = 5'($urandom_range(31, 0));
        funct3           = 3'($urandom_range(7, 0));
        row              = '0;
        row.instr        = {7'b0000000, rs2, rs1, funct3, rd, 7'b0110011};
        row.wr_en        = 1'($urandom_range(1, 0));
        row.wr_reg       = 5'($urandom_range(31, 0));
        row.wr_data      = {$urandom, $urandom};
        row.exp_op_code  = {funct3, 7'b0110011};
        row.exp_reg_dest = rd;
        row.exp_reg_a    = rs1;
        row.exp_src_b    = rs2;
        return row;
    endfunction

    task automatic apply_row(input vector_t row);
        xlen_t pc;
        xlen_t exp_a;
        xlen_t exp_b;
        pc = 64'h8000_0000 + 64'(row_count) * 64'd4;
        @(posedge clk);
        instr        <= row.instr;
        prog_counter <= pc;
        is_flush     <= row.flush;
        wr_en        <= row.wr_en;
        destn_reg    <= row.wr_reg;
        destn_data   <= row.wr_data;
        alu_reg_dest <= row.alu_dest;
        mem_reg_dest <= row.mem_dest;
        wb_reg_dest  <= row.wb_dest;
        alu_is_store <= row.alu_store;
        // captured at the next edge, sampled half a cycle later
        @(posedge clk);
        @(negedge clk);
        // read sees the registers before this row's write
        exp_a = row.exp_stall ? '0 : reg_model[row.exp_reg_a];
        exp_b = row.exp_stall ? '0 : reg_model[row.exp_src_b];
        check("op_code", 64'(op_code), 64'(row.exp_op_code));
        check("reg_dest", 64'(reg_dest), 64'(row.exp_reg_dest));
        check("reg_a", 64'(reg_a), 64'(row.exp_reg_a));
        check("imm12", 64'(imm12), 64'(row.exp_imm12));
        check("uimm", 64'(uimm), 64'(row.exp_uimm));
        check("stall", 64'(stall), 64'(row.exp_stall));
        check("rd_data_a", rd_data_a, exp_a);
        check("rd_data_b", rd_data_b, exp_b);
        check("curr_pc", curr_pc, pc);
        check("out_instr", 64'(out_instr), 64'(row.instr));
        // x0 never changes
        if (row.wr_en && (row.wr_reg != '0)) begin
            reg_model[row.wr_reg] = row.wr_data;
        end
        row_count++;
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(32'h9289_3fce));
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = '0;
        prog_counter = '0;
        is_flush     = 1'b0;
        wr_en        = 1'b0;
        destn_reg    = '0;
        destn_data   = '0;
        alu_reg_dest = '0;
        mem_reg_dest = '0;
        wb_reg_dest  = '0;
        alu_is_store = 1'b0;
        row_count    = 0;
        for (int r = 0; r < num_regs; r++) begin
            reg_model[r] = '0;
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // stall has to be low before the first row
        wait_cycles = 0;
        while ((stall !== 1'b0) && (wait_cycles < reset_timeout)) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (stall !== 1'b0) begin
            $display("timeout: stall still high %0d cycles after reset", reset_timeout);
            stop_with_failure();
        end

        // everything cleared by reset
        @(negedge clk);
        check("rd_data_a", rd_data_a, 64'h0);
        check("rd_data_b", rd_data_b, 64'h0);
        check("reg_dest", 64'(reg_dest), 64'h0);
        check("reg_a", 64'(reg_a), 64'h0);
        check("imm12", 64'(imm12), 64'h0);
        check("uimm", 64'(uimm), 64'h0);
        check("op_code", 64'(op_code), 64'h0);
        check("out_instr", 64'(out_instr), 64'h0);
        check("curr_pc", curr_pc, 64'h0);
        check("stall", 64'(stall), 64'h0);

        // every register reads zero on both ports
        for (int r = 0; r < num_regs; r++) begin
            apply_row(sweep_row(r));
        end

        for (int i = 0; i < num_vectors; i++) begin
            apply_row(vectors[i]);
        end

        for (int i = 0; i < num_random_rows; i++) begin
            apply_row(random_r_row());
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* flist.f */
+incdir+sim
common/decode_pkg.sv
decode/instr_field_decoder.sv
decode/hazard_detector.sv
decode/register_file.sv
decode/decode_stage.sv
sim/decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the decode stage testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps \
        -f flist.f --top-module decode_stage_tb \
    && ./obj_dir/Vdecode_stage_tb 2>&1 | tee /dev/stderr \
        | grep -q -x "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
